// ==== Makefile ====
# Verilator build and run of the two-VC link testbench
TOP := vc_link_tb

all: run

build:
	verilator --binary --timing --assert -j 0 -f vlog.f --top-module $(TOP) \
		-Mdir obj_dir -o $(TOP)

# The log decides pass or fail
run: build
	./obj_dir/$(TOP) | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

lint:
	verilator --lint-only --timing -f vlog.f --top-module vc_link_top

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

// ==== bench/vc_link_stimulus.txt ====
# T <name> <ready vc0> <ready vc1> <checks hex>  ready: a always, n never, r random
# F <vc> <flit hex> <idle gap>  checks: 1 latency, 2 round robin, 4 back-pressure hold
T single_vc0 a a 1
F 0 4502A001 0
F 0 80A00011 0
F 0 C0A00012 2
F 0 4701A002 0
F 0 C0A00021 0
T contention a a 2
F 0 4103B001 0
F 0 80B00011 0
F 0 80B00012 0
F 0 C0B00013 0
F 1 4203C001 0
F 1 80C00011 0
F 1 80C00012 0
F 1 C0C00013 0
T backpressure n a 4
F 0 4108D001 0
F 0 80D00011 0
F 0 80D00012 0
F 0 80D00013 0
F 0 80D00014 0
F 0 80D00015 0
F 0 80D00016 0
F 0 80D00017 0
F 0 C0D00018 0
F 1 4202E001 1
F 1 80E00011 1
F 1 C0E00012 1
T random_drain r r 0
F 0 4102F001 1
F 0 80F00011 0
F 0 C0F00012 1
F 1 4201F101 0
F 1 C0F10011 2
F 1 4201F102 0
F 1 C0F10012 0

// ==== bench/vc_link_tb.sv ====
// Testbench for the two-VC link driven from bench/vc_link_stimulus.txt
// Run from the project root so that the stimulus path resolves
// Inputs change on the falling edge where handshakes are also decided
// Only the round robin check peeks at the link wires inside dut_i
`timescale 1ns/100ps
`default_nettype none

module vc_link_tb;

  import noc_cfg_pkg::*;
  import noc_flit_pkg::*;

  localparam int NUM_CREDITS = 4;
  localparam int BUF_DEPTH   = 4;
  localparam int MAX_FLITS   = 256;
  localparam int MAX_TESTS   = 16;

  logic              clk;
  logic              rst_n;
  logic [NUM_VC-1:0] in_valid;
  logic [NUM_VC-1:0] in_ready;
  logic [NUM_VC-1:0] out_valid;
  logic [NUM_VC-1:0] out_ready;
  flit_u             in_flit [NUM_VC];
  flit_u             out_flit [NUM_VC];

  // Stimulus table with one entry per flit line
  logic [31:0]       flit_word [MAX_FLITS];
  int                flit_gap [MAX_FLITS];
  int                flit_vc [MAX_FLITS];
  int                flit_test [MAX_FLITS];
  logic [8*16-1:0]   test_name [MAX_TESTS];
  logic [7:0]        test_rdy [MAX_TESTS][NUM_VC];
  logic [3:0]        test_chk [MAX_TESTS];
  int                num_flits;
  int                num_tests;

  // Scoreboard of expected words and their input cycle per VC
  logic [31:0]       exp_q [NUM_VC][$];
  int                exp_cyc [NUM_VC][$];
  logic [7:0]        rem [NUM_VC];
  int                cycle;
  int                limit;
  int                seed;
  int                error_count;
  int                pass_tests;
  int                fail_tests;

  vc_link_top #(
    .NumCredits ( NUM_CREDITS ),
    .BufDepth   ( BUF_DEPTH   )
  ) dut_i (
    .clk_i       ( clk       ),
    .rst_n_i     ( rst_n     ),
    .in_valid_i  ( in_valid  ),
    .in_flit_i   ( in_flit   ),
    .in_ready_o  ( in_ready  ),
    .out_valid_o ( out_valid ),
    .out_flit_o  ( out_flit  ),
    .out_ready_i ( out_ready )
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Cycle count and run limit
  always @(posedge clk) begin
    cycle = cycle + 1;
    if (cycle > limit) begin
      $display("Run timed out after %0d cycles with flits still outstanding", cycle);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  //////////////////////////////
  // Stimulus file
  //////////////////////////////

  task automatic load_stimulus();
    int              fd;
    int              n;
    int              vc;
    int              gap;
    logic [8*128-1:0] line;
    logic [7:0]      key;
    logic [8*16-1:0] name;
    logic [7:0]      r0;
    logic [7:0]      r1;
    logic [3:0]      chk;
    logic [31:0]     word;
    fd = $fopen("bench/vc_link_stimulus.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file bench/vc_link_stimulus.txt");
      fail_tests++;
    end else begin
      while (!$feof(fd)) begin
        line = '0;
        key  = '0;
        n = $fgets(line, fd);
        if (n > 0) begin
          n = $sscanf(line, "%s", key);
        end
        // Section line opens a new test
        if (key == "T") begin
          n = $sscanf(line, "%s %s %s %s %h", key, name, r0, r1, chk);
          test_name[num_tests]   = name;
          test_rdy[num_tests][0] = r0;
          test_rdy[num_tests][1] = r1;
          test_chk[num_tests]    = chk;
          num_tests++;
        end else if (key == "F" && num_tests > 0) begin
          n = $sscanf(line, "%s %d %h %d", key, vc, word, gap);
          flit_vc[num_flits]   = vc;
          flit_word[num_flits] = word;
          flit_gap[num_flits]  = gap;
          flit_test[num_flits] = num_tests - 1;
          num_flits++;
        end
      end
      $fclose(fd);
    end
    limit = 40 * num_flits + 200;
  endtask

  // Next flit of test t on VC v after index from or -1 when none is left
  function automatic int next_flit(input int t, input int v, input int from);
    for (int j = from + 1; j < num_flits; j++) begin
      if (flit_test[j] == t && flit_vc[j] == v) begin
        return j;
      end
    end
    return -1;
  endfunction

  //////////////////////////////
  // Checks
  //////////////////////////////

  task automatic check_reset_outputs();
    assert (out_valid == '0 && in_ready == '1) else begin
      $display("FAILED at %0t: reset state out_valid=%b in_ready=%b",
               $time, out_valid, in_ready);
      error_count++;
    end
  endtask

  // Order, latency and framing of one delivered flit
  task automatic check_output(input int v, input logic [31:0] got, input logic chk_lat);
    logic [31:0] want;
    int          lat;
    assert (exp_q[v].size() != 0) else begin
      $display("Flit %h came out of VC%0d although none was outstanding", got, v);
      error_count++;
    end
    if (exp_q[v].size() != 0) begin
      want = exp_q[v].pop_front();
      lat  = cycle - exp_cyc[v].pop_front();
      assert (got == want) else begin
        $display("FAILED at %0t: VC%0d expected %h, got %h", $time, v, want, got);
        error_count++;
      end
      if (chk_lat) begin
        assert (lat == 2) else begin
          $display("FAILED at %0t: VC%0d flit %h latency %0d, expected 2",
                   $time, v, got, lat);
          error_count++;
        end
      end
    end
    // Head loads the flits still due and the tail must close the packet
    if (got[31:30] == KIND_HEAD) begin
      assert (rem[v] == '0) else begin
        $display("FAILED at %0t: VC%0d head %h inside a packet", $time, v, got);
        error_count++;
      end
      rem[v] = got[23:16];
    end else begin
      assert (rem[v] != '0 && ((got[31:30] == KIND_TAIL) == (rem[v] == 8'd1))) else begin
        $display("FAILED at %0t: VC%0d flit %h breaks framing, %0d due",
                 $time, v, got, rem[v]);
        error_count++;
      end
      if (rem[v] != '0) begin
        rem[v] = rem[v] - 8'd1;
      end
    end
  endtask

  //////////////////////////////
  // Test engine
  //////////////////////////////

  task automatic run_test(input int t);
    int          cur [NUM_VC];
    int          gap [NUM_VC];
    int          accepted [NUM_VC];
    int          stall [NUM_VC];
    logic [7:0]  mode [NUM_VC];
    logic [31:0] rnd;
    int          run_len;
    int          errors_before;
    int          other;
    vc_idx_t     last_win;
    logic        busy;
    errors_before = error_count;
    run_len       = 0;
    last_win      = '0;
    for (int v = 0; v < NUM_VC; v++) begin
      cur[v]      = next_flit(t, v, -1);
      gap[v]      = 0;
      accepted[v] = 0;
      stall[v]    = 0;
      mode[v]     = test_rdy[t][v];
    end
    busy = 1'b1;
    while (busy) begin
      @(negedge clk);
      for (int v = 0; v < NUM_VC; v++) begin
        // Output side drives ready and checks the handshake of the coming edge
        if (mode[v] == "r") begin
          rnd          = $random(seed);
          out_ready[v] = rnd[0];
        end else begin
          out_ready[v] = (mode[v] == "a");
        end
        if (out_valid[v] && out_ready[v]) begin
          check_output(v, out_flit[v], test_chk[t][0]);
        end
        // Input side waits out the idle gap first
        if (gap[v] > 0) begin
          in_valid[v] = 1'b0;
          gap[v]--;
        end else if (cur[v] >= 0) begin
          in_valid[v] = 1'b1;
          in_flit[v]  = flit_word[cur[v]];
          if (in_ready[v]) begin
            exp_q[v].push_back(flit_word[cur[v]]);
            exp_cyc[v].push_back(cycle);
            accepted[v]++;
            stall[v] = 0;
            gap[v]   = flit_gap[cur[v]];
            cur[v]   = next_flit(t, v, cur[v]);
          end else begin
            stall[v]++;
          end
        end else begin
          in_valid[v] = 1'b0;
        end
      end
      // Round robin allows no VC more than two wins in a row while both heads wait
      if (test_chk[t][1]) begin
        if (dut_i.link_valid && (&dut_i.head_valid)) begin
          if (run_len != 0 && dut_i.link_vc == last_win) begin
            run_len++;
          end else begin
            run_len = 1;
          end
          last_win = dut_i.link_vc;
          assert (run_len <= 2) else begin
            $display("FAILED at %0t: VC%0d won %0d transfers in a row",
                     $time, last_win, run_len);
            error_count++;
          end
        end else begin
          run_len = 0;
        end
      end
      // Held VC is released once the other VC is done and it has stalled
      for (int v = 0; v < NUM_VC; v++) begin
        other = 1 - v;
        if (mode[v] == "n" && stall[v] >= 8 && cur[other] < 0 && exp_q[other].size() == 0) begin
          if (test_chk[t][2]) begin
            assert (accepted[v] == NUM_CREDITS + BUF_DEPTH) else begin
              $display("FAILED at %0t: VC%0d took %0d flits before stalling, expected %0d",
                       $time, v, accepted[v], NUM_CREDITS + BUF_DEPTH);
              error_count++;
            end
          end
          mode[v] = "a";
        end
      end
      busy = 1'b0;
      for (int v = 0; v < NUM_VC; v++) begin
        if (cur[v] >= 0 || exp_q[v].size() != 0) begin
          busy = 1'b1;
        end
      end
    end
    if (error_count == errors_before) begin
      pass_tests++;
      $display("Test %0s: ok", test_name[t]);
    end else begin
      fail_tests++;
      $display("Test %0s: %0d errors", test_name[t], error_count - errors_before);
    end
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    seed        = 81;
    cycle       = 0;
    limit       = 200;
    num_flits   = 0;
    num_tests   = 0;
    error_count = 0;
    pass_tests  = 0;
    fail_tests  = 0;
    rst_n       = 1'b0;
    in_valid    = '0;
    out_ready   = '0;
    for (int v = 0; v < NUM_VC; v++) begin
      in_flit[v] = '0;
      rem[v]     = '0;
    end
    load_stimulus();
    // Reset is held for 16 cycles and outputs are checked once the state has settled
    for (int i = 1; i <= 16; i++) begin
      @(negedge clk);
      if (i >= 2) begin
        check_reset_outputs();
      end
    end
    rst_n = 1'b1;
    @(negedge clk);
    check_reset_outputs();
    if (error_count == 0) begin
      pass_tests++;
      $display("Test reset_state: ok");
    end else begin
      fail_tests++;
      $display("Test reset_state: %0d errors", error_count);
    end
    for (int t = 0; t < num_tests; t++) begin
      run_test(t);
    end
    $display("Tests finished: %0d passed, %0d failed", pass_tests, fail_tests);
    if (fail_tests == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== logic/link_sink.sv ====
// Far end of the link, one receive queue per VC
// Queue depth equals NumCredits, the link never writes a full queue
// Credit strobe is registered, high the cycle after a pop
// Framing checks assume packets are not interleaved within one VC
`timescale 1ns/100ps
`default_nettype none

module link_sink #(
  parameter int unsigned NumCredits = 4
) (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  // Physical link
  input  logic                           link_valid_i,
  input  noc_cfg_pkg::vc_idx_t           link_vc_i,
  input  noc_flit_pkg::flit_u            link_flit_i,
  // Delivery, one port per VC
  output logic [noc_cfg_pkg::NUM_VC-1:0] out_valid_o,
  output noc_flit_pkg::flit_u            out_flit_o [noc_cfg_pkg::NUM_VC],
  input  logic [noc_cfg_pkg::NUM_VC-1:0] out_ready_i,
  // Credit return
  output logic [noc_cfg_pkg::NUM_VC-1:0] credit_o
);

  import noc_cfg_pkg::*;
  import noc_flit_pkg::*;

  localparam int unsigned PtrW = (NumCredits > 1) ? $clog2(NumCredits) : 1;
  localparam int unsigned CntW = $clog2(NumCredits + 1);

  // Kind is read through the body view, len through the head view
  flit_kind_e link_kind;
  assign link_kind = link_flit_i.body.kind;

  for (genvar v = 0; v < NUM_VC; v++) begin : gen_vc
    flit_u           mem_q [NumCredits];
    logic [PtrW-1:0] wr_ptr_q;
    logic [PtrW-1:0] rd_ptr_q;
    logic [CntW-1:0] count_q;
    logic [7:0]      remaining_q;
    logic            credit_q;
    logic            push;
    logic            pop;

    assign push = link_valid_i && (link_vc_i == vc_idx_t'(v));
    assign pop  = out_valid_o[v] && out_ready_i[v];

    assign out_valid_o[v] = (count_q != '0);
    assign out_flit_o[v]  = mem_q[rd_ptr_q];
    assign credit_o[v]    = credit_q;

    // Queue control, credit strobe and packet tracking
    always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
        wr_ptr_q    <= '0;
        rd_ptr_q    <= '0;
        count_q     <= '0;
        remaining_q <= '0;
        credit_q    <= 1'b0;
      end else begin
        credit_q <= pop;
        if (push) begin
          wr_ptr_q <= (wr_ptr_q == PtrW'(NumCredits - 1)) ? '0 : wr_ptr_q + PtrW'(1);
          // Head loads the count, every later flit uses one up
          if (link_kind == KIND_HEAD) begin
            remaining_q <= link_flit_i.head.len;
          end else begin
            remaining_q <= remaining_q - 8'd1;
          end
        end
        if (pop) begin
          rd_ptr_q <= (rd_ptr_q == PtrW'(NumCredits - 1)) ? '0 : rd_ptr_q + PtrW'(1);
        end
        case ({push, pop})
          2'b10:   count_q <= count_q + CntW'(1);
          2'b01:   count_q <= count_q - CntW'(1);
          default: count_q <= count_q;
        endcase
      end
    end

    always_ff @(posedge clk_i) begin
      if (push) begin
        mem_q[wr_ptr_q] <= link_flit_i;
      end
    end

    // Credit loop keeps the queue from overflowing
    a_no_full_write: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      push |-> count_q < CntW'(NumCredits));

    // New packet only after the previous tail
    a_head_framing: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (push && link_kind == KIND_HEAD) |-> remaining_q == '0);

    // Body inside a packet, tail exactly on the last one due
    a_tail_framing: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (push && link_kind != KIND_HEAD) |->
        (remaining_q != '0) && ((link_kind == KIND_TAIL) == (remaining_q == 8'd1)));
  end

endmodule

`default_nettype wire

// ==== logic/noc_cfg_pkg.sv ====
// Link configuration shared by every block of the two-VC link
// Only two virtual channels are supported, the arbiter rotates between two
// Flit width is fixed by the head layout in the flit package
`default_nettype none

package noc_cfg_pkg;

  //////////////////////////////
  // Link dimensions
  //////////////////////////////

  // Number of virtual channels sharing the physical link
  localparam int unsigned NUM_VC = 2;

  // Width of one flit word
  localparam int unsigned FLIT_W = 32;

  // Index of a virtual channel on the link
  typedef logic [0:0] vc_idx_t;

endpackage

`default_nettype wire

// ==== logic/noc_flit_pkg.sv ====
// Flit formats carried on the link
// The kind field occupies the top two bits in every view of a flit
// Head layout is fixed at 32 bits, FLIT_W must match it
`default_nettype none

package noc_flit_pkg;

  // Flit kind, 2'b00 is not a legal kind
  typedef enum logic [1:0] {
    KIND_HEAD = 2'b01,
    KIND_BODY = 2'b10,
    KIND_TAIL = 2'b11
  } flit_kind_e;

  // Head view, len counts the body and tail flits that follow
  typedef struct packed {
    flit_kind_e  kind;
    logic [5:0]  dest;
    logic [7:0]  len;
    logic [15:0] tag;
  } head_fields_t;

  // Body and tail view
  typedef struct packed {
    flit_kind_e                        kind;
    logic [noc_cfg_pkg::FLIT_W-3:0]    payload;
  } body_fields_t;

  // One word, two readings
  typedef union packed {
    head_fields_t head;
    body_fields_t body;
  } flit_u;

endpackage

`default_nettype wire

// ==== logic/vc_credit_counter.sv ====
// Credit counter for one VC of the link
// Starts full at NumCredits, take and give may arrive in the same cycle
`timescale 1ns/100ps
`default_nettype none

module vc_credit_counter #(
  parameter int unsigned NumCredits = 4
) (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic take_i,
  input  logic give_i,
  output logic credit_left_o
);

  localparam int unsigned CntW = $clog2(NumCredits + 1);

  logic [CntW-1:0] credit_q;

  // Net change per cycle is -1, 0 or +1
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      credit_q <= CntW'(NumCredits);
    end else begin
      case ({take_i, give_i})
        2'b10:   credit_q <= credit_q - CntW'(1);
        2'b01:   credit_q <= credit_q + CntW'(1);
        default: credit_q <= credit_q;
      endcase
    end
  end

  assign credit_left_o = (credit_q != '0);

  // A grant is only given while a credit is held
  a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    take_i |-> credit_q != '0);

  // Far end never returns more than it was sent
  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (give_i && !take_i) |-> credit_q < CntW'(NumCredits));

endmodule

`default_nettype wire

// ==== logic/vc_input_buffer.sv ====
// Per-VC input queue, valid/ready on both sides
// A pushed flit is at the head one cycle later, no bypass path
// in_ready_o drops only when all BufDepth entries hold a flit
`timescale 1ns/100ps
`default_nettype none

module vc_input_buffer #(
  parameter int unsigned BufDepth = 4
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  // Upstream side
  input  logic                in_valid_i,
  input  noc_flit_pkg::flit_u in_flit_i,
  output logic                in_ready_o,
  // Towards the arbiter
  output logic                out_valid_o,
  output noc_flit_pkg::flit_u out_flit_o,
  input  logic                out_ready_i
);

  import noc_flit_pkg::*;

  localparam int unsigned PtrW = (BufDepth > 1) ? $clog2(BufDepth) : 1;
  localparam int unsigned CntW = $clog2(BufDepth + 1);

  flit_u           mem_q [BufDepth];
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [CntW-1:0] count_q;
  logic            push;
  logic            pop;

  // Wrap at BufDepth, depth need not be a power of two
  function automatic logic [PtrW-1:0] ptr_inc(input logic [PtrW-1:0] ptr);
    if (ptr == PtrW'(BufDepth - 1)) begin
      return '0;
    end
    return ptr + PtrW'(1);
  endfunction

  //////////////////////////////
  // Handshakes
  //////////////////////////////

  assign in_ready_o  = (count_q != CntW'(BufDepth));
  assign out_valid_o = (count_q != '0);
  assign out_flit_o  = mem_q[rd_ptr_q];

  assign push = in_valid_i & in_ready_o;
  assign pop  = out_valid_o & out_ready_i;

  // Pointers and fill level
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + CntW'(1);
        2'b01:   count_q <= count_q - CntW'(1);
        default: count_q <= count_q;
      endcase
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= in_flit_i;
    end
  end

  // Fill level stays within the storage
  a_count_bound: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    count_q <= CntW'(BufDepth));

endmodule

`default_nettype wire

// ==== logic/vc_link_arbiter.sv ====
// Credit-gated round-robin of the VC queue heads onto one physical link
// Single physical channel, two VCs, credit mode only
// Fully combinational from heads to link and the grant pops the head the same cycle
// The link has no ready since credits guarantee room at the far end
`timescale 1ns/100ps
`default_nettype none

module vc_link_arbiter #(
  parameter int unsigned NumCredits = 4
) (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  // One queue head per VC
  input  logic [noc_cfg_pkg::NUM_VC-1:0]    vc_valid_i,
  input  noc_flit_pkg::flit_u               vc_flit_i [noc_cfg_pkg::NUM_VC],
  output logic [noc_cfg_pkg::NUM_VC-1:0]    vc_ready_o,
  // Physical link
  output logic                              link_valid_o,
  output noc_cfg_pkg::vc_idx_t              link_vc_o,
  output noc_flit_pkg::flit_u               link_flit_o,
  // Credit return strobes from the sink
  input  logic [noc_cfg_pkg::NUM_VC-1:0]    credit_i
);

  import noc_cfg_pkg::*;

  logic [NUM_VC-1:0] credit_left;
  logic [NUM_VC-1:0] req;
  vc_idx_t           last_q;
  vc_idx_t           win;

  //////////////////////////////
  // Request and grant
  //////////////////////////////

  // A VC competes with a valid head and at least one credit
  assign req = vc_valid_i & credit_left;

  // The VC after the last winner goes first
  // otherwise the last winner keeps the link if it still requests
  assign win = req[~last_q] ? ~last_q : last_q;

  assign link_valid_o = |req;
  assign link_vc_o    = win;
  assign link_flit_o  = vc_flit_i[win];

  // Grant is onehot on the winner and zero when nobody requests
  always_comb begin
    vc_ready_o      = '0;
    vc_ready_o[win] = link_valid_o;
  end

  // Last winner resets to VC1 so that VC0 has the first turn
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      last_q <= vc_idx_t'(NUM_VC - 1);
    end else if (link_valid_o) begin
      last_q <= win;
    end
  end

  //////////////////////////////
  // Credits
  //////////////////////////////

  for (genvar v = 0; v < NUM_VC; v++) begin : gen_credit
    // Grant doubles as the credit take
    vc_credit_counter #(
      .NumCredits ( NumCredits )
    ) i_credit (
      .clk_i         ( clk_i          ),
      .rst_n_i       ( rst_n_i        ),
      .take_i        ( vc_ready_o[v]  ),
      .give_i        ( credit_i[v]    ),
      .credit_left_o ( credit_left[v] )
    );
  end

  //////////////////////////////
  // Checks
  //////////////////////////////

  // One VC on the link at a time
  a_grant_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(vc_ready_o));

endmodule

`default_nettype wire

// ==== logic/vc_link_top.sv ====
// Two-VC link, input queues, credit arbiter and far-end sink
// Idle latency from input handshake to out_valid_o is 2 cycles
`timescale 1ns/100ps
`default_nettype none

module vc_link_top #(
  parameter int unsigned NumCredits = 4,
  parameter int unsigned BufDepth   = 4
) (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  logic [noc_cfg_pkg::NUM_VC-1:0] in_valid_i,
  input  noc_flit_pkg::flit_u            in_flit_i [noc_cfg_pkg::NUM_VC],
  output logic [noc_cfg_pkg::NUM_VC-1:0] in_ready_o,
  output logic [noc_cfg_pkg::NUM_VC-1:0] out_valid_o,
  output noc_flit_pkg::flit_u            out_flit_o [noc_cfg_pkg::NUM_VC],
  input  logic [noc_cfg_pkg::NUM_VC-1:0] out_ready_i
);

  import noc_cfg_pkg::*;
  import noc_flit_pkg::*;

  // Queue heads towards the arbiter
  logic [NUM_VC-1:0] head_valid;
  logic [NUM_VC-1:0] head_ready;
  flit_u             head_flit [NUM_VC];
  // Physical link and credit return
  logic              link_valid;
  vc_idx_t           link_vc;
  flit_u             link_flit;
  logic [NUM_VC-1:0] credit;

  for (genvar v = 0; v < NUM_VC; v++) begin : gen_in_buf
    vc_input_buffer #(
      .BufDepth ( BufDepth )
    ) i_in_buf (
      .clk_i       ( clk_i         ),
      .rst_n_i     ( rst_n_i       ),
      .in_valid_i  ( in_valid_i[v] ),
      .in_flit_i   ( in_flit_i[v]  ),
      .in_ready_o  ( in_ready_o[v] ),
      .out_valid_o ( head_valid[v] ),
      .out_flit_o  ( head_flit[v]  ),
      .out_ready_i ( head_ready[v] )
    );
  end

  vc_link_arbiter #(
    .NumCredits ( NumCredits )
  ) i_arbiter (
    .clk_i        ( clk_i      ),
    .rst_n_i      ( rst_n_i    ),
    .vc_valid_i   ( head_valid ),
    .vc_flit_i    ( head_flit  ),
    .vc_ready_o   ( head_ready ),
    .link_valid_o ( link_valid ),
    .link_vc_o    ( link_vc    ),
    .link_flit_o  ( link_flit  ),
    .credit_i     ( credit     )
  );

  link_sink #(
    .NumCredits ( NumCredits )
  ) i_sink (
    .clk_i        ( clk_i       ),
    .rst_n_i      ( rst_n_i     ),
    .link_valid_i ( link_valid  ),
    .link_vc_i    ( link_vc     ),
    .link_flit_i  ( link_flit   ),
    .out_valid_o  ( out_valid_o ),
    .out_flit_o   ( out_flit_o  ),
    .out_ready_i  ( out_ready_i ),
    .credit_o     ( credit      )
  );

endmodule

`default_nettype wire

// ==== vlog.f ====
logic/noc_cfg_pkg.sv
logic/noc_flit_pkg.sv
logic/vc_input_buffer.sv
logic/vc_credit_counter.sv
logic/vc_link_arbiter.sv
logic/link_sink.sv
logic/vc_link_top.sv
bench/vc_link_tb.sv
